// File: cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`default_nettype none

// Datapath and address widths
`define XLEN 32              // Data word
`define ADDR_W 12            // Byte address on both ports
`define REG_IDX_W 5          // Register index
`define NUM_REGS 32          // Register file depth

// Program counter
`define PC_STEP 4            // One word per instruction
`define RESET_PC 0           // First fetch address

// Instruction encoding
`define IMM_W 14             // Sign-extended immediate field

`default_nettype wire

`endif

// File: cpu_pkg.sv
`include "cpu_defines.svh"

`default_nettype none

package cpu_pkg;

	// Opcode byte, bits 7:0 of the instruction
	typedef enum logic [7:0] {
		OP_NOP  = 8'h00,
		OP_ADD  = 8'h01,
		OP_SUB  = 8'h02,
		OP_XOR  = 8'h03,
		OP_OR   = 8'h04,
		OP_AND  = 8'h05,
		OP_SLL  = 8'h06,
		OP_SRL  = 8'h07,
		OP_SLE  = 8'h08,
		OP_ADDI = 8'h10,
		OP_LW   = 8'h20,
		OP_SW   = 8'h21
	} opcodeT;

	// ALU function select
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_XOR = 4'd2,
		ALU_OR  = 4'd3,
		ALU_AND = 4'd4,
		ALU_SLL = 4'd5,
		ALU_SRL = 4'd6,
		ALU_SLE = 4'd7   // Unsigned a <= b
	} aluOpT;

	// Decoded controls; all zero is a bubble
	typedef struct packed {
		aluOpT aluOp;
		logic useImm;     // Operand b from immediate
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic memToReg;   // Writeback takes load data
	} ctrlT;

	typedef struct packed {
		logic [`XLEN-1:0] instr;
		logic [`ADDR_W-1:0] pcInc;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		logic [`REG_IDX_W-1:0] ra;
		logic [`REG_IDX_W-1:0] rb;
		logic [`REG_IDX_W-1:0] rd;        // Destination, or store data source for SW
		logic [`XLEN-1:0] opA;
		logic [`XLEN-1:0] opB;
		logic [`XLEN-1:0] storeData;
		logic [`XLEN-1:0] imm;
	} idExT;

	typedef struct packed {
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic memToReg;
		logic [`XLEN-1:0] aluResult;
		logic [`XLEN-1:0] storeData;
		logic [`REG_IDX_W-1:0] rd;
	} exMemT;

	// Writeback bus, seen by decode and execute
	typedef struct packed {
		logic we;
		logic [`REG_IDX_W-1:0] rd;
		logic [`XLEN-1:0] data;
	} wbT;

	typedef struct packed {
		logic ready;
		logic [`XLEN-1:0] instr;
	} imemRspT;

	typedef struct packed {
		logic valid;
		logic write;                  // 1 for store
		logic [`ADDR_W-1:0] addr;
		logic [`XLEN-1:0] writeData;
	} dmemReqT;

	typedef struct packed {
		logic ready;
		logic [`XLEN-1:0] readData;   // Valid with ready on a load
	} dmemRspT;

endpackage

`default_nettype wire

// File: fetchStage.sv
`include "cpu_defines.svh"

`default_nettype none

module fetchStage (
	input logic clk,
	input logic reset,
	input logic freeze,
	input logic holdFetch,
	output logic instrRequest,
	output logic [`ADDR_W-1:0] pc,
	input cpu_pkg::imemRspT imemRsp,
	output cpu_pkg::ifIdT ifId
);

	logic accept;                 // Instruction taken this edge
	logic [`ADDR_W-1:0] pcNext;

	// Port stays quiet only while reset is held
	assign instrRequest = !reset;

	assign accept = instrRequest && imemRsp.ready && !freeze && !holdFetch;
	assign pcNext = pc + `ADDR_W'(`PC_STEP);

	// Program counter
	always_ff @(posedge clk) begin
		if (reset)
			pc <= `ADDR_W'(`RESET_PC);
		else if (accept)
			pc <= pcNext;
	end

	// Fetch/decode register, NOP after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			ifId.instr <= '0;   // Opcode 0 is NOP
			ifId.pcInc <= '0;
		end else if (accept) begin
			ifId.instr <= imemRsp.instr;
			ifId.pcInc <= pcNext;
		end
	end

endmodule

`default_nettype wire

// File: decodeStage.sv
`include "cpu_defines.svh"

`default_nettype none

module decodeStage (
	input logic clk,
	input logic reset,
	input logic freeze,
	input logic insertBubble,
	input cpu_pkg::ifIdT ifId,
	input cpu_pkg::wbT wb,
	output cpu_pkg::idExT idEx,
	output logic [`REG_IDX_W-1:0] decRa,
	output logic [`REG_IDX_W-1:0] decRb
);
	import cpu_pkg::*;

	opcodeT opcode;
	ctrlT ctrl;
	logic [`REG_IDX_W-1:0] raField;
	logic [`REG_IDX_W-1:0] rbField;
	logic [`REG_IDX_W-1:0] rdField;
	logic [`XLEN-1:0] immExt;
	logic [`XLEN-1:0] regFile [`NUM_REGS];
	logic [`XLEN-1:0] readA;
	logic [`XLEN-1:0] readB;
	logic [`XLEN-1:0] readS;      // Store data via rd field

	// Register 0 reads zero, writeback passes straight through
	function automatic logic [`XLEN-1:0] readPort(
		input logic [`REG_IDX_W-1:0] idx,
		input logic [`XLEN-1:0] stored,
		input wbT w
	);
		if (idx == '0)
			return '0;
		else if (w.we && w.rd == idx)
			return w.data;
		else
			return stored;
	endfunction

	assign opcode = opcodeT'(ifId.instr[7:0]);
	assign rdField = ifId.instr[31:27];
	assign raField = ifId.instr[26:22];
	assign rbField = ifId.instr[21:17];
	assign immExt = {{(`XLEN-`IMM_W){ifId.instr[21]}}, ifId.instr[21:8]};

	// Sources seen by the load-use check
	assign decRa = raField;
	assign decRb = ctrl.memWrite ? rdField : rbField;

	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND, OP_SLL, OP_SRL, OP_SLE:
				ctrl.regWrite = 1'b1;
			OP_ADDI: begin
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OP_LW: begin
				ctrl.useImm = 1'b1;   // Address = ra + imm
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OP_SW: begin
				ctrl.useImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			default: ctrl = '0;   // NOP and unknown opcodes
		endcase
		case (opcode)
			OP_SUB: ctrl.aluOp = ALU_SUB;
			OP_XOR: ctrl.aluOp = ALU_XOR;
			OP_OR: ctrl.aluOp = ALU_OR;
			OP_AND: ctrl.aluOp = ALU_AND;
			OP_SLL: ctrl.aluOp = ALU_SLL;
			OP_SRL: ctrl.aluOp = ALU_SRL;
			OP_SLE: ctrl.aluOp = ALU_SLE;
			default: ctrl.aluOp = ALU_ADD;   // ADD, ADDI, address adds
		endcase
	end

	// Register file, entry 0 never written
	always_ff @(posedge clk) begin
		if (wb.we && wb.rd != '0)
			regFile[wb.rd] <= wb.data;
	end

	assign readA = readPort(raField, regFile[raField], wb);
	assign readB = readPort(rbField, regFile[rbField], wb);
	assign readS = readPort(rdField, regFile[rdField], wb);

	// Decode/execute register
	always_ff @(posedge clk) begin
		if (reset) begin
			idEx.ctrl <= '0;
		end else if (!freeze) begin
			idEx.ctrl <= insertBubble ? ctrlT'('0) : ctrl;   // Load-use bubble
			idEx.ra <= raField;
			idEx.rb <= rbField;
			idEx.rd <= rdField;
			idEx.opA <= readA;
			idEx.opB <= readB;
			idEx.storeData <= readS;
			idEx.imm <= immExt;
		end
	end

endmodule

`default_nettype wire

// File: hazardUnit.sv
`include "cpu_defines.svh"

`default_nettype none

module hazardUnit (
	input logic instrRequest,
	input cpu_pkg::imemRspT imemRsp,
	input cpu_pkg::dmemReqT dmemReq,
	input cpu_pkg::dmemRspT dmemRsp,
	input cpu_pkg::idExT idEx,
	input logic [`REG_IDX_W-1:0] decRa,
	input logic [`REG_IDX_W-1:0] decRb,
	output logic freeze,
	output logic holdFetch,
	output logic insertBubble
);

	logic imemWait;
	logic dmemWait;
	logic loadUse;

	// Either port still waiting for ready
	assign imemWait = instrRequest && !imemRsp.ready;
	assign dmemWait = dmemReq.valid && !dmemRsp.ready;
	assign freeze = imemWait || dmemWait;

	// Load in execute feeds the instruction in decode
	always_comb begin
		loadUse = 1'b0;
		if (idEx.ctrl.memRead && idEx.rd != '0)
			loadUse = (idEx.rd == decRa) || (idEx.rd == decRb);
	end

	// Freeze wins, so the stall waits until the ports move
	assign holdFetch = loadUse && !freeze;
	assign insertBubble = loadUse && !freeze;

endmodule

`default_nettype wire

// File: executeStage.sv
`include "cpu_defines.svh"

`default_nettype none

module executeStage (
	input logic clk,
	input logic reset,
	input logic freeze,
	input cpu_pkg::idExT idEx,
	output cpu_pkg::exMemT exMem,
	input cpu_pkg::wbT wb
);
	import cpu_pkg::*;

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opBReg;          // Forwarded rb value
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] storeData;
	logic [`XLEN-1:0] aluResult;
	logic [$clog2(`XLEN)-1:0] shamt;

	// Newest producer first, loads in memory excluded
	function automatic logic [`XLEN-1:0] forward(
		input logic [`REG_IDX_W-1:0] src,
		input logic [`XLEN-1:0] regVal,
		input exMemT em,
		input wbT w
	);
		if (em.regWrite && !em.memRead && em.rd != '0 && em.rd == src)
			return em.aluResult;
		else if (w.we && w.rd != '0 && w.rd == src)
			return w.data;
		else
			return regVal;
	endfunction

	assign opA = forward(idEx.ra, idEx.opA, exMem, wb);
	assign opBReg = forward(idEx.rb, idEx.opB, exMem, wb);
	assign storeData = forward(idEx.rd, idEx.storeData, exMem, wb);   // SW source is rd field

	assign opB = idEx.ctrl.useImm ? idEx.imm : opBReg;
	assign shamt = opB[$clog2(`XLEN)-1:0];

	always_comb begin
		case (idEx.ctrl.aluOp)
			ALU_ADD: aluResult = opA + opB;
			ALU_SUB: aluResult = opA - opB;
			ALU_XOR: aluResult = opA ^ opB;
			ALU_OR: aluResult = opA | opB;
			ALU_AND: aluResult = opA & opB;
			ALU_SLL: aluResult = opA << shamt;
			ALU_SRL: aluResult = opA >> shamt;
			ALU_SLE: aluResult = (opA <= opB) ? `XLEN'(1) : '0;   // Unsigned compare
			default: aluResult = opA + opB;
		endcase
	end

	// Execute/memory register
	always_ff @(posedge clk) begin
		if (reset) begin
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
		end else if (!freeze) begin
			exMem.memRead <= idEx.ctrl.memRead;
			exMem.memWrite <= idEx.ctrl.memWrite;
			exMem.regWrite <= idEx.ctrl.regWrite;
			exMem.memToReg <= idEx.ctrl.memToReg;
			exMem.aluResult <= aluResult;
			exMem.storeData <= storeData;
			exMem.rd <= idEx.rd;
		end
	end

endmodule

`default_nettype wire

// File: memStage.sv
`include "cpu_defines.svh"

`default_nettype none

module memStage (
	input logic clk,
	input logic reset,
	input logic freeze,
	input cpu_pkg::exMemT exMem,
	output cpu_pkg::dmemReqT dmemReq,
	input cpu_pkg::dmemRspT dmemRsp,
	output cpu_pkg::wbT wb
);

	logic [`XLEN-1:0] wbValue;

	// Request held by the freeze until ready
	assign dmemReq.valid = exMem.memRead || exMem.memWrite;
	assign dmemReq.write = exMem.memWrite;
	assign dmemReq.addr = exMem.aluResult[`ADDR_W-1:0];   // Byte address from ALU
	assign dmemReq.writeData = exMem.storeData;

	// Load data arrives with ready
	assign wbValue = exMem.memToReg ? dmemRsp.readData : exMem.aluResult;

	// Memory/writeback register drives the bus directly
	always_ff @(posedge clk) begin
		if (reset) begin
			wb.we <= 1'b0;
		end else if (!freeze) begin
			wb.we <= exMem.regWrite;
			wb.rd <= exMem.rd;
			wb.data <= wbValue;
		end
	end

endmodule

`default_nettype wire

// File: cpuTop.sv
`include "cpu_defines.svh"

`default_nettype none

module cpuTop (
	input logic clk,
	input logic reset,
	output logic instrRequest,
	output logic [`ADDR_W-1:0] pc,
	input cpu_pkg::imemRspT imemRsp,
	output cpu_pkg::dmemReqT dmemReq,
	input cpu_pkg::dmemRspT dmemRsp
);
	import cpu_pkg::*;

	logic freeze;          // Port wait, whole pipe holds
	logic holdFetch;       // Load-use, PC and IF/ID hold
	logic insertBubble;
	ifIdT ifId;
	idExT idEx;
	exMemT exMem;
	wbT wb;
	logic [`REG_IDX_W-1:0] decRa;
	logic [`REG_IDX_W-1:0] decRb;

	fetchStage u_fetch (
		.clk(clk),
		.reset(reset),
		.freeze(freeze),
		.holdFetch(holdFetch),
		.instrRequest(instrRequest),
		.pc(pc),
		.imemRsp(imemRsp),
		.ifId(ifId)
	);

	decodeStage u_decode (
		.clk(clk),
		.reset(reset),
		.freeze(freeze),
		.insertBubble(insertBubble),
		.ifId(ifId),
		.wb(wb),
		.idEx(idEx),
		.decRa(decRa),
		.decRb(decRb)
	);

	hazardUnit u_hazard (
		.instrRequest(instrRequest),
		.imemRsp(imemRsp),
		.dmemReq(dmemReq),
		.dmemRsp(dmemRsp),
		.idEx(idEx),
		.decRa(decRa),
		.decRb(decRb),
		.freeze(freeze),
		.holdFetch(holdFetch),
		.insertBubble(insertBubble)
	);

	executeStage u_execute (
		.clk(clk),
		.reset(reset),
		.freeze(freeze),
		.idEx(idEx),
		.exMem(exMem),
		.wb(wb)
	);

	memStage u_mem (
		.clk(clk),
		.reset(reset),
		.freeze(freeze),
		.exMem(exMem),
		.dmemReq(dmemReq),
		.dmemRsp(dmemRsp),
		.wb(wb)
	);

endmodule

`default_nettype wire

// File: tbMemory.sv
`include "cpu_defines.svh"

`default_nettype none

module tbMemory (
	input logic clk,
	input logic reset,
	input logic randomWaits,   // Adds 0 to 3 wait cycles per access
	input logic instrRequest,
	input logic [`ADDR_W-1:0] pc,
	output cpu_pkg::imemRspT imemRsp,
	input cpu_pkg::dmemReqT dmemReq,
	output cpu_pkg::dmemRspT dmemRsp,
	output logic done
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS = (1 << `ADDR_W) / 4;
	localparam logic [`ADDR_W-1:0] END_ADDR = `ADDR_W'('hFFC);

	logic [`XLEN-1:0] imem [WORDS];
	logic [`XLEN-1:0] dmem [WORDS];
	logic [`ADDR_W-1:0] logAddr [$];   // Store log, in completion order
	logic [`XLEN-1:0] logData [$];
	logic [31:0] rngState = 32'd9978;
	logic [`ADDR_W-1:0] lastPc;
	logic iStarted;
	logic dActive;                    // Data access in progress
	int iWait;
	int dWait;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int pickWait();
		if (!randomWaits)
			return 0;
		rngState = xorshift(rngState);
		return int'(rngState[1:0]);
	endfunction

	initial begin
		imemRsp = '0;
		dmemRsp = '0;
		done = 1'b0;
		iStarted = 1'b0;
		dActive = 1'b0;
		iWait = 0;
		dWait = 0;
	end

	// Port signals settled here; a data access ends only when the pipe moves
	always @(negedge clk) begin
		if (!reset && dmemReq.valid && dmemRsp.ready && !(instrRequest && !imemRsp.ready)) begin
			dActive = 1'b0;
			if (dmemReq.write) begin
				dmem[dmemReq.addr[`ADDR_W-1:2]] = dmemReq.writeData;
				if (dmemReq.addr == END_ADDR) begin
					done = 1'b1;   // End of program
				end else begin
					logAddr.push_back(dmemReq.addr);
					logData.push_back(dmemReq.writeData);
				end
			end
		end
	end

	// Responses change after the testbench's own drive point
	always @(posedge clk) begin
		#2;
		if (reset) begin
			iStarted = 1'b0;
			dActive = 1'b0;
			iWait = 0;
			dWait = 0;
			done = 1'b0;
			logAddr.delete();
			logData.delete();
			imemRsp.ready = 1'b0;
			dmemRsp.ready = 1'b0;
		end else begin
			if (instrRequest && (!iStarted || pc != lastPc)) begin
				iStarted = 1'b1;   // New fetch address
				lastPc = pc;
				iWait = pickWait();
			end else if (iWait > 0) begin
				iWait--;
			end
			imemRsp.ready = instrRequest && iWait == 0;
			imemRsp.instr = imem[pc[`ADDR_W-1:2]];
			if (dmemReq.valid && !dActive) begin
				dActive = 1'b1;
				dWait = pickWait();
			end else if (dWait > 0) begin
				dWait--;
			end
			dmemRsp.ready = dmemReq.valid && dWait == 0;
			dmemRsp.readData = dmem[dmemReq.addr[`ADDR_W-1:2]];   // Word aligned
		end
	end

endmodule

`default_nettype wire

// File: cpu_props.sv
`default_nettype none

module cpuProps (
	input logic clk,
	input logic reset,
	input logic instrRequest,
	input cpu_pkg::dmemReqT dmemReq,
	input cpu_pkg::dmemRspT dmemRsp
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;   // Assertion failures so far

	// Stage registers cleared after one reset edge
	quietDataInReset: assert property (@(posedge clk) reset && $past(reset) |-> !dmemReq.valid)
		else begin
			failCount++;
			$error("data request while reset is held");
		end

	// Waiting request keeps address, direction and store data
	stableDataRequest: assert property (@(posedge clk) disable iff (reset)
		dmemReq.valid && !dmemRsp.ready |=> dmemReq.valid && $stable(dmemReq.addr)
			&& $stable(dmemReq.write) && (!dmemReq.write || $stable(dmemReq.writeData)))
		else begin
			failCount++;
			$error("data request changed while waiting for ready");
		end

	quietFetchInReset: assert property (@(posedge clk) reset |-> !instrRequest)
		else begin
			failCount++;
			$error("instruction request while reset is held");
		end

endmodule

bind cpuTop cpuProps u_props (
	.clk(clk),
	.reset(reset),
	.instrRequest(instrRequest),
	.dmemReq(dmemReq),
	.dmemRsp(dmemRsp)
);

`default_nettype wire

// File: cpuTb.sv
`include "cpu_defines.svh"

`default_nettype none

module cpuTb;
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int RUN_TIMEOUT = 2000;   // Cycles per program
	localparam int WORDS = (1 << `ADDR_W) / 4;
	localparam logic [`IMM_W-1:0] END_IMM = `IMM_W'('hFFC);

	logic clk;
	logic reset;
	logic randomWaits;
	logic instrRequest;
	logic done;
	logic [`ADDR_W-1:0] pc;
	imemRspT imemRsp;
	dmemReqT dmemReq;
	dmemRspT dmemRsp;

	// Program image and reference machine
	logic [`XLEN-1:0] prog [$];
	logic [`XLEN-1:0] refRegs [`NUM_REGS];
	logic [`XLEN-1:0] refMem [logic [`ADDR_W-1:0]];
	logic [`ADDR_W-1:0] expAddr [$];
	logic [`XLEN-1:0] expData [$];
	string testName;

	cpuTop u_dut (
		.clk(clk),
		.reset(reset),
		.instrRequest(instrRequest),
		.pc(pc),
		.imemRsp(imemRsp),
		.dmemReq(dmemReq),
		.dmemRsp(dmemRsp)
	);

	tbMemory memModel (
		.clk(clk),
		.reset(reset),
		.randomWaits(randomWaits),
		.instrRequest(instrRequest),
		.pc(pc),
		.imemRsp(imemRsp),
		.dmemReq(dmemReq),
		.dmemRsp(dmemRsp),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abortRun();
		$display("test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkEqual(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s %s expected %h actual %h", testName, what, expected, actual);
			abortRun();
		end
	endtask

	// Port protocol watch on the bound checker
	always @(negedge clk) begin
		if (u_dut.u_props.failCount != 0) begin
			$display("Port protocol assertion failed in %s", testName);
			abortRun();
		end
	end

	// Untouched data words hold a pattern unique per address
	function automatic logic [`XLEN-1:0] fillWord(input logic [`ADDR_W-1:0] addr);
		return {8'hD0, addr, ~addr};
	endfunction

	function automatic logic [`XLEN-1:0] signExtend(input logic [`IMM_W-1:0] imm);
		return {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};
	endfunction

	// Instruction semantics
	function automatic logic [`XLEN-1:0] aluModel(input opcodeT op, input logic [31:0] a,
			input logic [31:0] b);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_XOR: return a ^ b;
			OP_OR: return a | b;
			OP_AND: return a & b;
			OP_SLL: return a << b[4:0];
			OP_SRL: return a >> b[4:0];
			OP_SLE: return (a <= b) ? 32'd1 : 32'd0;   // Unsigned
			default: return '0;
		endcase
	endfunction

	task automatic writeRef(input logic [`REG_IDX_W-1:0] rd, input logic [`XLEN-1:0] value);
		if (rd != '0)
			refRegs[rd] = value;   // r0 stays zero
	endtask

	task automatic newProgram(input string name);
		testName = name;
		prog.delete();
		refMem.delete();
		expAddr.delete();
		expData.delete();
		foreach (refRegs[i])
			refRegs[i] = '0;
	endtask

	task automatic emitAlu(input opcodeT op, input logic [`REG_IDX_W-1:0] rd,
			input logic [`REG_IDX_W-1:0] ra, input logic [`REG_IDX_W-1:0] rb);
		prog.push_back({rd, ra, rb, 9'd0, op});
		writeRef(rd, aluModel(op, refRegs[ra], refRegs[rb]));
	endtask

	task automatic emitAddi(input logic [`REG_IDX_W-1:0] rd, input logic [`REG_IDX_W-1:0] ra,
			input logic [`IMM_W-1:0] imm);
		prog.push_back({rd, ra, imm, OP_ADDI});
		writeRef(rd, refRegs[ra] + signExtend(imm));
	endtask

	task automatic emitLw(input logic [`REG_IDX_W-1:0] rd, input logic [`REG_IDX_W-1:0] ra,
			input logic [`IMM_W-1:0] imm);
		logic [`XLEN-1:0] sum;
		logic [`ADDR_W-1:0] addr;
		sum = refRegs[ra] + signExtend(imm);
		addr = sum[`ADDR_W-1:0];
		prog.push_back({rd, ra, imm, OP_LW});
		writeRef(rd, refMem.exists(addr) ? refMem[addr] : fillWord(addr));
	endtask

	// Store data register sits in the rd field
	task automatic emitSw(input logic [`REG_IDX_W-1:0] rs, input logic [`REG_IDX_W-1:0] ra,
			input logic [`IMM_W-1:0] imm);
		logic [`XLEN-1:0] sum;
		logic [`ADDR_W-1:0] addr;
		sum = refRegs[ra] + signExtend(imm);
		addr = sum[`ADDR_W-1:0];
		prog.push_back({rs, ra, imm, OP_SW});
		refMem[addr] = refRegs[rs];
		if (addr != `ADDR_W'('hFFC)) begin
			expAddr.push_back(addr);
			expData.push_back(refRegs[rs]);
		end
	endtask

	task automatic emitNops(input int n);
		repeat (n) prog.push_back('0);
	endtask

	task automatic seedRegs();
		emitAddi(1, 0, 14'd1234);
		emitAddi(2, 0, 14'(-77));   // Negative immediate
		emitAddi(3, 0, 14'd5);
		emitAddi(4, 0, 14'h3FFF);   // All ones
	endtask

	// Reset, load, run to the end store, then compare store logs
	task automatic runProgram(input logic randomMode);
		int cycles;
		emitSw(0, 0, END_IMM);
		emitNops(4);
		@(posedge clk);
		#1;
		reset = 1'b1;
		randomWaits = randomMode;
		for (int i = 0; i < WORDS; i++) begin
			memModel.imem[i] = (i < prog.size()) ? prog[i] : '0;
			memModel.dmem[i] = fillWord(`ADDR_W'(i << 2));
		end
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			if (i > 0)
				checkEqual("data request in reset", 0, dmemReq.valid);
			@(posedge clk);
			#1;
		end
		reset = 1'b0;
		@(negedge clk);
		checkEqual("fetch request after reset", 1, instrRequest);
		checkEqual("first fetch address", `RESET_PC, pc);
		cycles = 0;
		while (!done && cycles < RUN_TIMEOUT) begin
			@(posedge clk);   // Done is set at the falling edge
			cycles++;
		end
		if (!done) begin
			$display("Timeout in %s, no end store after %0d cycles", testName, cycles);
			abortRun();
		end
		checkEqual("store count", expAddr.size(), memModel.logAddr.size());
		foreach (expAddr[i]) begin
			checkEqual($sformatf("store %0d address", i), expAddr[i], memModel.logAddr[i]);
			checkEqual($sformatf("store %0d data", i), expData[i], memModel.logData[i]);
		end
	endtask

	task automatic testReset();
		newProgram("reset");
		emitNops(2);
		runProgram(1'b0);
	endtask

	// Every ALU op isolated by NOPs
	task automatic testAlu(input logic randomMode);
		opcodeT ops [8];
		ops = '{OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND, OP_SLL, OP_SRL, OP_SLE};
		newProgram(randomMode ? "alu random" : "alu");
		seedRegs();
		foreach (ops[k]) begin
			emitNops(3);
			emitAlu(ops[k], 5, 1, 2);
			emitNops(3);
			emitSw(5, 0, 14'(256 + 4 * k));
		end
		emitNops(3);
		emitAlu(OP_SLE, 6, 2, 1);   // False case
		emitNops(3);
		emitAlu(OP_SRL, 7, 4, 3);
		emitNops(3);
		emitSw(6, 0, 14'h140);
		emitSw(7, 0, 14'h144);
		runProgram(randomMode);
	endtask

	// Back-to-back dependencies
	task automatic testForward(input logic randomMode);
		newProgram(randomMode ? "forward random" : "forward");
		seedRegs();
		emitAlu(OP_ADD, 6, 1, 2);
		emitAlu(OP_XOR, 7, 6, 1);
		emitAlu(OP_SUB, 8, 7, 6);
		emitSw(8, 0, 14'h200);   // Data just computed
		emitAlu(OP_SLL, 9, 8, 3);
		emitSw(9, 0, 14'h204);
		emitAlu(OP_OR, 10, 9, 7);
		emitAlu(OP_AND, 11, 10, 8);
		emitAddi(12, 0, 14'h208);
		emitSw(11, 12, 14'd0);   // Base just computed
		emitSw(10, 12, 14'd4);
		emitAlu(OP_SLE, 13, 11, 10);
		emitSw(13, 12, 14'd8);
		runProgram(randomMode);
	endtask

	task automatic testLoadUse(input logic randomMode);
		newProgram(randomMode ? "load-use random" : "load-use");
		seedRegs();
		emitSw(1, 0, 14'h300);
		emitLw(13, 0, 14'h300);
		emitAlu(OP_ADD, 14, 13, 2);   // Needs the load at once
		emitSw(14, 0, 14'h304);
		emitLw(15, 0, 14'h304);
		emitSw(15, 0, 14'h308);       // Loaded value as store data
		emitAddi(16, 0, 14'h310);
		emitSw(16, 0, 14'h30C);
		emitLw(17, 0, 14'h30C);
		emitSw(3, 17, 14'd0);         // Loaded value as address
		emitLw(18, 0, 14'h310);
		emitAddi(19, 18, 14'd7);
		emitSw(19, 0, 14'h314);
		emitLw(20, 0, 14'h400);       // Never written
		emitSw(20, 0, 14'h318);
		runProgram(randomMode);
	endtask

	task automatic testRegZero();
		newProgram("register zero");
		seedRegs();
		emitAddi(0, 0, 14'd55);
		emitAddi(21, 0, 14'd9);       // Must not see the 55
		emitAlu(OP_ADD, 0, 1, 1);
		emitAlu(OP_ADD, 22, 0, 1);
		emitSw(0, 0, 14'h500);
		emitSw(21, 0, 14'h504);
		emitSw(22, 0, 14'h508);
		emitSw(1, 0, 14'h50C);
		emitLw(0, 0, 14'h50C);
		emitAlu(OP_OR, 23, 0, 0);
		emitSw(23, 0, 14'h510);
		runProgram(1'b0);
	endtask

	initial begin
		reset = 1'b1;
		randomWaits = 1'b0;
		testReset();
		testAlu(1'b0);
		testForward(1'b0);
		testLoadUse(1'b0);
		testAlu(1'b1);   // Same programs with random port latency
		testForward(1'b1);
		testLoadUse(1'b1);
		testRegZero();
		@(negedge clk);   // Assertions of the last edge have run
		if (u_dut.u_props.failCount == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("Port protocol assertion failed %0d times", u_dut.u_props.failCount);
			abortRun();
		end
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
cpu_pkg.sv
fetchStage.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memStage.sv
cpuTop.sv
tbMemory.sv
cpu_props.sv
cpuTb.sv
